// ==== src/iq_pkg.sv ====
`default_nettype none

package iq_pkg;

    // queue and bus sizes
    localparam int IQ_DEPTH   = 8;
    localparam int CDB_COUNT  = 2;
    localparam int WKUP_COUNT = 2;

    localparam int ROB_ID_W = 5;
    localparam int WORD_W   = 32;
    localparam int OP_W     = 6;
    localparam int IQ_IDX_W = 3;

    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [OP_W-1:0]     op_t;
    typedef logic [IQ_IDX_W-1:0] iq_idx_t;

    // one source operand as dispatched, tag only meaningful while not ready
    typedef struct packed {
        logic    ready;
        rob_id_t tag;
        word_t   value;
    } src_op_t;

    // one CDB lane, lane k only carries tags with tag[0] == k
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    // early wakeup, data follows one cycle later
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
    } wkup_t;

    typedef struct packed {
        op_t     op;
        rob_id_t dest;
        src_op_t src0;
        src_op_t src1;
    } dispatch_t;

    typedef struct packed {
        op_t     op;
        rob_id_t dest;
        word_t   src0;
        word_t   src1;
    } issue_t;

endpackage

`default_nettype wire

// ==== src/iq_operand_slot.sv ====
`timescale 1ns/100ps
`default_nettype none

module iq_operand_slot (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n_i,
    input  wire logic                                       load_i,
    input  wire iq_pkg::src_op_t                            load_op_i,
    input  wire logic                                       issued_i,
    input  wire iq_pkg::cdb_t   [iq_pkg::CDB_COUNT-1:0]     cdb_i,
    input  wire iq_pkg::wkup_t  [iq_pkg::WKUP_COUNT-1:0]    wkup_i,
    input  wire iq_pkg::word_t  [iq_pkg::WKUP_COUNT-1:0]    wkup_data_i,
    output logic                                            ready_o,
    output iq_pkg::word_t                                   value_o
);

    import iq_pkg::*;

    logic                  ready_q;
    rob_id_t               tag_q;
    word_t                 value_q;
    logic [WKUP_COUNT-1:0] wkup_sel_q;

    logic [CDB_COUNT-1:0]  cdb_hit;
    logic [WKUP_COUNT-1:0] wkup_hit;
    word_t                 cdb_value;
    word_t                 wkup_value;

    // cdb snoop, a lane only counts when its index matches the tag parity
    always_comb begin
        cdb_value = '0;
        for (int k = 0; k < CDB_COUNT; k++) begin
            cdb_hit[k] = !ready_q && cdb_i[k].valid && (tag_q[0] == 1'(k)) &&
                         (cdb_i[k].tag == tag_q);
            if (cdb_hit[k]) begin
                cdb_value = cdb_value | cdb_i[k].data;
            end
        end
    end

    // tag match now, data steered in from wkup_data_i next cycle
    always_comb begin
        wkup_value = '0;
        for (int j = 0; j < WKUP_COUNT; j++) begin
            wkup_hit[j] = !ready_q && wkup_i[j].valid && (wkup_i[j].tag == tag_q);
            if (wkup_sel_q[j]) begin
                wkup_value = wkup_value | wkup_data_i[j];
            end
        end
    end

    // idle slots sit at ready so they never snoop
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ready_q    <= 1'b1;
            wkup_sel_q <= '0;
        end else if (load_i) begin
            ready_q    <= load_op_i.ready;
            wkup_sel_q <= '0;
        end else if (issued_i) begin
            ready_q    <= 1'b1;
            wkup_sel_q <= '0;
        end else begin
            if (|cdb_hit || |wkup_hit) begin
                ready_q <= 1'b1;
            end
            wkup_sel_q <= wkup_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            tag_q   <= load_op_i.tag;
            value_q <= load_op_i.value;
        end else if (|cdb_hit) begin
            value_q <= cdb_value;
        end else if (|wkup_sel_q) begin
            // keep the forwarded word once its cycle on the bus is over
            value_q <= wkup_value;
        end
    end

    assign ready_o = ready_q;
    assign value_o = (|wkup_sel_q) ? wkup_value : value_q;

    // rob tags are unique, so two early wakeups never name the same producer
    wkup_single_hit_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(wkup_hit)
    ) else $error("operand slot matched more than one wakeup source");

endmodule

`default_nettype wire

// ==== src/iq_entry.sv ====
`timescale 1ns/100ps
`default_nettype none

module iq_entry (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n_i,
    input  wire logic                                       flush_i,
    input  wire logic                                       load_i,
    input  wire iq_pkg::dispatch_t                          dispatch_i,
    input  wire logic                                       sel_i,
    input  wire iq_pkg::cdb_t   [iq_pkg::CDB_COUNT-1:0]     cdb_i,
    input  wire iq_pkg::wkup_t  [iq_pkg::WKUP_COUNT-1:0]    wkup_i,
    input  wire iq_pkg::word_t  [iq_pkg::WKUP_COUNT-1:0]    wkup_data_i,
    output logic                                            valid_o,
    output logic                                            ready_o,
    output iq_pkg::issue_t                                  payload_o
);

    import iq_pkg::*;

    logic    valid_q;
    op_t     op_q;
    rob_id_t dest_q;
    logic    take;
    logic    release_slots;
    logic    src0_ready;
    logic    src1_ready;
    word_t   src0_value;
    word_t   src1_value;

    // a dispatch landing in a flush cycle is dropped
    assign take          = load_i & !flush_i;
    assign release_slots = sel_i | flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (sel_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q   <= dispatch_i.op;
            dest_q <= dispatch_i.dest;
        end
    end

    iq_operand_slot src0_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_i      (take),
        .load_op_i   (dispatch_i.src0),
        .issued_i    (release_slots),
        .cdb_i       (cdb_i),
        .wkup_i      (wkup_i),
        .wkup_data_i (wkup_data_i),
        .ready_o     (src0_ready),
        .value_o     (src0_value)
    );

    iq_operand_slot src1_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_i      (take),
        .load_op_i   (dispatch_i.src1),
        .issued_i    (release_slots),
        .cdb_i       (cdb_i),
        .wkup_i      (wkup_i),
        .wkup_data_i (wkup_data_i),
        .ready_o     (src1_ready),
        .value_o     (src1_value)
    );

    // slot ready already covers last cycle's wakeups, whose data is on the bus now
    assign valid_o   = valid_q;
    assign ready_o   = valid_q & src0_ready & src1_ready;
    assign payload_o = '{op: op_q, dest: dest_q, src0: src0_value, src1: src1_value};

    // allocation must only ever pick a free entry
    load_free_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        load_i |-> !valid_q
    ) else $error("dispatch loaded an entry that is still valid");

endmodule

`default_nettype wire

// ==== src/iq_alloc.sv ====
`timescale 1ns/100ps
`default_nettype none

module iq_alloc (
    input  wire logic [iq_pkg::IQ_DEPTH-1:0] entry_valid_i,
    output logic      [iq_pkg::IQ_DEPTH-1:0] alloc_oh_o,
    output logic                             full_o
);

    import iq_pkg::*;

    logic [IQ_DEPTH-1:0] free;

    assign free = ~entry_valid_i;

    // lowest free entry wins
    always_comb begin
        alloc_oh_o = '0;
        for (int k = IQ_DEPTH - 1; k >= 0; k--) begin
            if (free[k]) begin
                alloc_oh_o    = '0;
                alloc_oh_o[k] = 1'b1;
            end
        end
    end

    assign full_o = ~|free;

endmodule

`default_nettype wire

// ==== src/iq_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module iq_select (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   flush_i,
    input  wire logic           [iq_pkg::IQ_DEPTH-1:0]  ready_i,
    input  wire iq_pkg::issue_t [iq_pkg::IQ_DEPTH-1:0]  payload_i,
    output logic                [iq_pkg::IQ_DEPTH-1:0]  sel_oh_o,
    output logic                                        issue_valid_o,
    output iq_pkg::issue_t                              issue_o
);

    import iq_pkg::*;

    iq_idx_t sel_idx;
    logic    sel_any;

    // fixed priority with entry 0 first
    always_comb begin
        sel_idx = '0;
        sel_any = 1'b0;
        for (int k = IQ_DEPTH - 1; k >= 0; k--) begin
            if (ready_i[k]) begin
                sel_idx = iq_idx_t'(k);
                sel_any = 1'b1;
            end
        end
        sel_oh_o = '0;
        if (sel_any) begin
            sel_oh_o[sel_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= sel_any & !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_any) begin
            issue_o <= payload_i[sel_idx];
        end
    end

    // the granted entry has to leave the ready vector at the next edge
    sel_release_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        sel_any |=> ((ready_i & $past(sel_oh_o)) == '0)
    ) else $error("granted entry still ready after its issue cycle");

endmodule

`default_nettype wire

// ==== src/issue_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_queue (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n_i,
    input  wire logic                                       flush_i,
    input  wire logic                                       dispatch_valid_i,
    input  wire iq_pkg::dispatch_t                          dispatch_i,
    input  wire iq_pkg::cdb_t   [iq_pkg::CDB_COUNT-1:0]     cdb_i,
    input  wire iq_pkg::wkup_t  [iq_pkg::WKUP_COUNT-1:0]    wkup_i,
    input  wire iq_pkg::word_t  [iq_pkg::WKUP_COUNT-1:0]    wkup_data_i,
    output logic                                            issue_valid_o,
    output iq_pkg::issue_t                                  issue_o,
    output logic                                            full_o
);

    import iq_pkg::*;

    logic   [IQ_DEPTH-1:0] entry_valid;
    logic   [IQ_DEPTH-1:0] entry_ready;
    logic   [IQ_DEPTH-1:0] alloc_oh;
    logic   [IQ_DEPTH-1:0] entry_load;
    logic   [IQ_DEPTH-1:0] sel_oh;
    issue_t [IQ_DEPTH-1:0] entry_payload;

    assign entry_load = alloc_oh & {IQ_DEPTH{dispatch_valid_i}};

    iq_alloc alloc_i (
        .entry_valid_i (entry_valid),
        .alloc_oh_o    (alloc_oh),
        .full_o        (full_o)
    );

    for (genvar k = 0; k < IQ_DEPTH; k++) begin : g_entry
        iq_entry entry_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .load_i      (entry_load[k]),
            .dispatch_i  (dispatch_i),
            .sel_i       (sel_oh[k]),
            .cdb_i       (cdb_i),
            .wkup_i      (wkup_i),
            .wkup_data_i (wkup_data_i),
            .valid_o     (entry_valid[k]),
            .ready_o     (entry_ready[k]),
            .payload_o   (entry_payload[k])
        );
    end

    iq_select select_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .ready_i       (entry_ready),
        .payload_i     (entry_payload),
        .sel_oh_o      (sel_oh),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o)
    );

    // no back-pressure, so rename has to stall on full
    no_dispatch_when_full_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        full_o |-> !dispatch_valid_i
    ) else $error("dispatch while issue queue is full");

endmodule

`default_nettype wire

// ==== tests/issue_queue_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_queue_tb;

    import iq_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_ROWS   = 8;

    typedef enum logic [1:0] {EV_NONE, EV_CDB, EV_WKUP} ev_kind_e;

    // what gets dispatched and how its waiting operands are woken
    typedef struct packed {
        int       count;
        logic     s0_ready;
        rob_id_t  s0_tag;
        logic     s1_ready;
        rob_id_t  s1_tag;
        ev_kind_e kind;
        int       delay;
        logic     decoy;
        logic     flush;
    } test_row_t;

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    logic                   flush_i;
    logic                   dispatch_valid_i;
    dispatch_t              dispatch_i;
    cdb_t  [CDB_COUNT-1:0]  cdb_i;
    wkup_t [WKUP_COUNT-1:0] wkup_i;
    word_t [WKUP_COUNT-1:0] wkup_data_i;
    logic                   issue_valid_o;
    issue_t                 issue_o;
    logic                   full_o;

    test_row_t   rows[NUM_ROWS];
    string       names[NUM_ROWS];
    int          n_rows = 0;
    logic        rows_loaded = 1'b0;
    int          errors = 0;
    int          failed_tests = 0;
    logic [15:0] lfsr_q = 16'd15813;

    issue_queue dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .cdb_i            (cdb_i),
        .wkup_i           (wkup_i),
        .wkup_data_i      (wkup_data_i),
        .issue_valid_o    (issue_valid_o),
        .issue_o          (issue_o),
        .full_o           (full_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic word_t lfsr_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[WORD_W-2:0], fb};
        end
        return v;
    endfunction

    function automatic int test_length(input test_row_t row);
        return 2 * row.count + row.delay + 6;
    endfunction

    task automatic add_row(input string name, input int count, input logic s0_ready,
                           input rob_id_t s0_tag, input logic s1_ready, input rob_id_t s1_tag,
                           input ev_kind_e kind, input int delay, input logic decoy,
                           input logic flush);
        names[n_rows] = name;
        rows[n_rows]  = '{count, s0_ready, s0_tag, s1_ready, s1_tag, kind, delay, decoy, flush};
        n_rows++;
    endtask

    task automatic load_table();
        //      name            count     s0 rdy/tag    s1 rdy/tag    event    dly decoy flush
        add_row("ready_issue",  1,        1'b1, 5'd0,  1'b1, 5'd0,  EV_NONE, 0, 1'b0, 1'b0);
        add_row("cdb_odd_tag",  1,        1'b0, 5'd5,  1'b1, 5'd0,  EV_CDB,  2, 1'b1, 1'b0);
        add_row("cdb_even_tag", 1,        1'b1, 5'd0,  1'b0, 5'd10, EV_CDB,  1, 1'b1, 1'b0);
        add_row("wkup_src0",    1,        1'b0, 5'd7,  1'b1, 5'd0,  EV_WKUP, 1, 1'b0, 1'b0);
        add_row("wkup_both",    1,        1'b0, 5'd12, 1'b0, 5'd13, EV_WKUP, 2, 1'b0, 1'b0);
        add_row("fill_cdb",     IQ_DEPTH, 1'b0, 5'd20, 1'b0, 5'd21, EV_CDB,  1, 1'b0, 1'b0);
        add_row("fill_wkup",    IQ_DEPTH, 1'b1, 5'd0,  1'b0, 5'd9,  EV_WKUP, 1, 1'b0, 1'b0);
        add_row("fill_flush",   IQ_DEPTH, 1'b0, 5'd22, 1'b1, 5'd0,  EV_CDB,  3, 1'b0, 1'b1);
    endtask

    task automatic run_test(input int r);
        test_row_t              row;
        dispatch_t              disp[IQ_DEPTH];
        issue_t                 exp_q[IQ_DEPTH];
        cdb_t  [CDB_COUNT-1:0]  cdb_event;
        wkup_t [WKUP_COUNT-1:0] wkup_event;
        word_t [WKUP_COUNT-1:0] wkup_data_event;
        word_t                  data0;
        word_t                  data1;
        word_t                  junk;
        logic                   lane;
        int                     ev_cycle;
        int                     n_exp;
        int                     n_got;
        int                     errors_before;
        row           = rows[r];
        ev_cycle      = row.count - 1 + row.delay;
        n_exp         = row.flush ? 0 : row.count;
        n_got         = 0;
        errors_before = errors;
        data0         = lfsr_bits(WORD_W);
        data1         = lfsr_bits(WORD_W);
        junk          = lfsr_bits(WORD_W);

        // one broadcast per waiting tag, cdb lane by tag parity
        cdb_event       = '0;
        wkup_event      = '0;
        wkup_data_event = '0;
        if (!row.s0_ready) begin
            cdb_event[row.s0_tag[0]] = '{1'b1, row.s0_tag, data0};
            wkup_event[0]            = '{1'b1, row.s0_tag};
            wkup_data_event[0]       = data0;
        end
        if (!row.s1_ready) begin
            cdb_event[row.s1_tag[0]] = '{1'b1, row.s1_tag, data1};
            wkup_event[1]            = '{1'b1, row.s1_tag};
            wkup_data_event[1]       = data1;
        end
        // same tag on the other lane, should be ignored
        if (row.decoy) begin
            lane            = row.s0_ready ? ~row.s1_tag[0] : ~row.s0_tag[0];
            cdb_event[lane] = '{1'b1, row.s0_ready ? row.s1_tag : row.s0_tag, junk};
        end

        // ready operands keep the dispatched word, waiting ones take the broadcast data
        for (int i = 0; i < row.count; i++) begin
            disp[i].op    = op_t'(lfsr_bits(OP_W));
            disp[i].dest  = rob_id_t'(lfsr_bits(ROB_ID_W));
            disp[i].src0  = '{row.s0_ready, row.s0_tag, lfsr_bits(WORD_W)};
            disp[i].src1  = '{row.s1_ready, row.s1_tag, lfsr_bits(WORD_W)};
            exp_q[i].op   = disp[i].op;
            exp_q[i].dest = disp[i].dest;
            exp_q[i].src0 = row.s0_ready ? disp[i].src0.value : data0;
            exp_q[i].src1 = row.s1_ready ? disp[i].src1.value : data1;
        end

        for (int c = 0; c < test_length(row); c++) begin
            @(posedge clk);
            if (c < row.count) begin
                dispatch_valid_i <= 1'b1;
                dispatch_i       <= disp[c];
            end else begin
                dispatch_valid_i <= 1'b0;
                dispatch_i       <= '0;
            end
            flush_i     <= row.flush && (c == row.count);
            cdb_i       <= (row.kind == EV_CDB && c == ev_cycle) ? cdb_event : '0;
            wkup_i      <= (row.kind == EV_WKUP && c == ev_cycle) ? wkup_event : '0;
            wkup_data_i <= (row.kind == EV_WKUP && c == ev_cycle + 1) ? wkup_data_event : '0;

            @(negedge clk);
            if (row.count == IQ_DEPTH && c == row.count) begin
                assert (full_o) else begin
                    $display("%s: full_o low with every entry in use", names[r]);
                    errors++;
                end
            end
            if (row.flush && c == row.count + 1) begin
                assert (!full_o) else begin
                    $display("%s: full_o still high after the flush", names[r]);
                    errors++;
                end
            end
            if (issue_valid_o) begin
                assert (n_got < n_exp) else begin
                    $display("%s: issue in cycle %0d with nothing left to issue", names[r], c);
                    errors++;
                end
                if (n_got < n_exp) begin
                    assert (issue_o == exp_q[n_got]) else begin
                        $display("FAILED %s: expected %h actual %h", names[r],
                                 exp_q[n_got], issue_o);
                        errors++;
                    end
                    assert (c == ev_cycle + 2 + n_got) else begin
                        $display("FAILED %s: issue cycle expected %0d actual %0d", names[r],
                                 ev_cycle + 2 + n_got, c);
                        errors++;
                    end
                end
                n_got++;
            end
            if (n_got == n_exp && c > ev_cycle + 2) begin
                break;
            end
        end

        assert (n_got == n_exp) else begin
            $display("%s: only %0d of %0d issues arrived in time", names[r], n_got, n_exp);
            errors++;
        end
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("%s: %0d of %0d issued, %0d errors", names[r], n_got, n_exp,
                 errors - errors_before);
    endtask

    initial begin : watchdog
        int budget;
        wait (rows_loaded);
        budget = 4;
        for (int r = 0; r < n_rows; r++) begin
            budget += test_length(rows[r]);
        end
        #(2 * budget * CLK_PERIOD);
        $display("watchdog: run went past %0d cycles without finishing", 2 * budget);
        $display("test failed");
        $finish;
    end

    initial begin
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_i       = '0;
        cdb_i            = '0;
        wkup_i           = '0;
        wkup_data_i      = '0;
        load_table();
        rows_loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (!issue_valid_o && !full_o) else begin
            $display("queue not idle after reset");
            errors++;
        end
        for (int r = 0; r < n_rows; r++) begin
            run_test(r);
        end
        $display("%0d tests run, %0d failing, %0d errors", n_rows, failed_tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== issue_queue.f ====
src/iq_pkg.sv
src/iq_operand_slot.sv
src/iq_entry.sv
src/iq_alloc.sv
src/iq_select.sv
src/issue_queue.sv
tests/issue_queue_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f issue_queue.f \
    --top-module issue_queue_tb \
    -Mdir obj_dir

# assertion failures stop the simulator; the search below decides the result
output=$(./obj_dir/Vissue_queue_tb 2>&1) || true
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
